// File: common/divsqrt_pkg.sv
/*
 * Divide / square-root package
 * Widths, destination formats, operation codes, pipeline placement
 * and the request / response payloads shared by the unit
 */
`default_nettype none

package divsqrt_pkg;

  // ------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------
  localparam int unsigned MAX_WIDTH = 32;  // Widest operand, one word
  localparam int unsigned TAG_WIDTH = 8;   // Caller tag

  // Destination format, selects the active low bits of each operand
  typedef enum logic [1:0] {
    W8  = 2'd0,
    W16 = 2'd1,
    W32 = 2'd2
  } fp_format_e;

  // Codes 2 and 3 are unused and run as a square root
  typedef enum logic [1:0] {
    DIV  = 2'd0,
    SQRT = 2'd1
  } operation_e;

  // Placement of the pipeline registers around the unit
  typedef enum logic [1:0] {
    BEFORE      = 2'd0,
    AFTER       = 2'd1,
    DISTRIBUTED = 2'd2
  } pipe_config_e;

  typedef struct packed {
    logic dz;  // Divide by zero
    logic nx;  // Nonzero remainder
  } status_t;

  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic                 mask;
  } sideband_t;

  typedef struct packed {
    logic [MAX_WIDTH-1:0] opa;  // Dividend or radicand
    logic [MAX_WIDTH-1:0] opb;  // Divisor
    operation_e           op;
    fp_format_e           fmt;
    sideband_t            sb;
  } in_req_t;

  typedef struct packed {
    logic [MAX_WIDTH-1:0] result;
    status_t              status;
    sideband_t            sb;
  } out_rsp_t;

  // Bit width of a format, unknown codes fall back to the full word
  function automatic int unsigned format_width(fp_format_e fmt);
    case (fmt)
      W8:      return 8;
      W16:     return 16;
      default: return MAX_WIDTH;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: divsqrt/divsqrt_pipe.sv
/*
 * Elastic register pipeline
 * NumRegs enabled stages with bubble popping ready and a synchronous
 * flush of all valid bits, generic over the payload type
 */
`timescale 1ns/10ps
`default_nettype none

module divsqrt_pipe #(
  parameter int unsigned NumRegs   = 0,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o,
  output logic     busy_o     // Some stage holds an item
);

  // Index i is the signal after i register stages
  logic     [0:NumRegs] valid;
  logic     [0:NumRegs] ready;  // Combinational for all stages
  payload_t             data [0:NumRegs];

  assign valid[0]       = valid_i;
  assign data[0]        = data_i;
  assign ready_o        = ready[0];
  assign ready[NumRegs] = ready_i;  // Driven from downstream

  // ------------------------------------------------------------------
  // Register stages
  // ------------------------------------------------------------------
  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic     valid_q;
    payload_t data_q;
    logic     reg_en;

    // Advance when the next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid[i+1];
    assign reg_en   = ready[i] & valid[i];   // Load only real items

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0;                  // Drop whatever is in flight
      end else if (ready[i]) begin
        valid_q <= valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_en) begin
        data_q <= data[i];
      end
    end

    assign valid[i+1] = valid_q;
    assign data[i+1]  = data_q;
  end

  assign valid_o = valid[NumRegs];
  assign data_o  = data[NumRegs];

  // Only registered stages count as work in flight
  if (NumRegs > 0) begin : gen_busy
    assign busy_o = |valid[1:NumRegs];
  end else begin : gen_no_busy
    assign busy_o = 1'b0;                 // Plain wires hold nothing
  end

endmodule

`default_nettype wire

// File: divsqrt/divsqrt_ctrl.sv
/*
 * Divide / square-root control FSM
 * Issues requests to the iterative unit, carries tag and mask while the
 * operation runs and presents the result with valid/ready
 */
`timescale 1ns/10ps
`default_nettype none

module divsqrt_ctrl (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     flush_i,
  // Request from the input pipe
  input  divsqrt_pkg::in_req_t                     req_i,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  // Iterative unit
  output logic                                     start_o,
  input  logic                                     unit_busy_i,
  input  logic                                     unit_done_i,
  input  logic [divsqrt_pkg::MAX_WIDTH-1:0]        unit_result_i,
  input  divsqrt_pkg::status_t                     unit_status_i,
  // Response to the output pipe
  output divsqrt_pkg::out_rsp_t                    rsp_o,
  output logic                                     rsp_valid_o,
  input  logic                                     rsp_ready_i,
  output logic                                     busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e                 state_q, state_d;
  divsqrt_pkg::sideband_t sb_q;  // Side-band of the running operation

  // Flush wins over a new issue
  assign start_o = req_valid_i & req_ready_o & ~flush_i;

  // ------------------------------------------------------------------
  // Next state and handshake
  // ------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    busy_o      = 1'b0;

    unique case (state_q)
      IDLE: begin
        req_ready_o = ~unit_busy_i;
        if (req_valid_i && !unit_busy_i) state_d = BUSY;
      end
      BUSY: begin
        busy_o = 1'b1;
        if (unit_done_i) begin
          rsp_valid_o = 1'b1;             // Result valid with done
          if (rsp_ready_i) begin
            req_ready_o = 1'b1;           // Back-to-back issue allowed
            state_d     = req_valid_i ? BUSY : IDLE;
          end else begin
            state_d = HOLD;               // Downstream stalled
          end
        end
      end
      HOLD: begin
        busy_o      = 1'b1;
        rsp_valid_o = 1'b1;               // Unit keeps result stable
        if (rsp_ready_i) begin
          req_ready_o = ~unit_busy_i;
          state_d     = (req_valid_i && !unit_busy_i) ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush cancels everything
    if (flush_i) begin
      rsp_valid_o = 1'b0;
      busy_o      = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) state_q <= IDLE;
    else          state_q <= state_d;
  end

  // Tag and mask ride along beside the operation
  always_ff @(posedge clk_i) begin
    if (start_o) sb_q <= req_i.sb;
  end

  assign rsp_o.result = unit_result_i;
  assign rsp_o.status = unit_status_i;
  assign rsp_o.sb     = sb_q;

endmodule

`default_nettype wire

// File: divsqrt/divsqrt_iter_unit.sv
/*
 * Iterative divide / square-root datapath
 * Radix-2 restoring division or digit-by-digit square root, one result
 * bit per cycle over the format width, with narrow results boxed to ones
 */
`timescale 1ns/10ps
`default_nettype none

module divsqrt_iter_unit (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              flush_i,
  input  logic                              start_i,
  input  divsqrt_pkg::operation_e           op_i,
  input  divsqrt_pkg::fp_format_e           fmt_i,
  input  logic [divsqrt_pkg::MAX_WIDTH-1:0] opa_i,
  input  logic [divsqrt_pkg::MAX_WIDTH-1:0] opb_i,
  output logic                              busy_o,
  output logic                              done_o,  // One cycle pulse
  output logic [divsqrt_pkg::MAX_WIDTH-1:0] result_o,
  output divsqrt_pkg::status_t              status_o
);

  localparam int unsigned W = divsqrt_pkg::MAX_WIDTH;

  // Ones in the low w bits
  function automatic logic [W-1:0] low_mask(int unsigned w);
    logic [W-1:0] ones;
    ones = '1;
    return ones >> (W - w);
  endfunction

  // ------------------------------------------------------------------
  // Operand preparation
  // ------------------------------------------------------------------
  int unsigned  fmt_w;      // Active width of the new request
  logic [W-1:0] fmt_mask;
  logic [W-1:0] opa_m, opb_m;
  logic         is_div;
  logic [5:0]   load_cnt;   // Result bits to produce

  assign fmt_w    = divsqrt_pkg::format_width(fmt_i);
  assign fmt_mask = low_mask(fmt_w);
  assign opa_m    = opa_i & fmt_mask;   // Narrow formats use low bits
  assign opb_m    = opb_i & fmt_mask;
  assign is_div   = (op_i == divsqrt_pkg::DIV);  // Other codes run sqrt
  assign load_cnt = is_div ? 6'(fmt_w) : 6'(fmt_w >> 1);

  // Control state
  logic       busy_q, done_q;
  logic [5:0] cnt_q;

  // Datapath registers
  logic         is_div_q;
  logic [W-1:0] keep_q;     // Format mask, zeros get boxed
  logic [W-1:0] acc_q;      // Left-aligned dividend / radicand bits
  logic [W-1:0] divisor_q;
  logic [W-1:0] rem_q;      // Partial remainder
  logic [W-1:0] res_q;      // Quotient or root, shifted in at LSB

  // ------------------------------------------------------------------
  // One iteration
  // ------------------------------------------------------------------
  logic [W+1:0] trial, sub;
  logic [W+2:0] diff;
  logic         take;       // New result bit
  logic         dz;

  always_comb begin
    if (is_div_q) begin
      trial = {1'b0, rem_q, acc_q[W-1]};  // Bring down one bit
      sub   = {2'b00, divisor_q};
    end else begin
      trial = {rem_q, acc_q[W-1 -: 2]};   // Bring down two bits
      sub   = {res_q, 2'b01};             // 4*root + 1
    end
    diff = {1'b0, trial} - {1'b0, sub};
    take = ~diff[W+2];                    // No borrow, keep difference
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;                     // Abort the running operation
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= load_cnt;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 6'd1;
        if (cnt_q == 6'd1) begin          // Last bit this cycle
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      is_div_q  <= is_div;
      keep_q    <= fmt_mask;
      acc_q     <= opa_m << (W - fmt_w);
      divisor_q <= opb_m;
      rem_q     <= '0;
      res_q     <= '0;
    end else if (busy_q) begin
      rem_q <= take ? diff[W-1:0] : trial[W-1:0];
      acc_q <= is_div_q ? (acc_q << 1) : (acc_q << 2);
      res_q <= {res_q[W-2:0], take};
    end
  end

  // ------------------------------------------------------------------
  // Result, held until the next start
  // ------------------------------------------------------------------
  assign dz       = is_div_q & (divisor_q == '0);
  assign result_o = dz ? '1 : (res_q | ~keep_q);  // Box upper bits
  assign status_o.dz = dz;
  assign status_o.nx = ~dz & (|rem_q);  // No remainder meaning under dz
  assign busy_o   = busy_q;
  assign done_o   = done_q;

endmodule

`default_nettype wire

// File: verilog/divsqrt_top.sv
/*
 * Divide / square-root top level
 * Input pipe, control FSM, iterative unit and output pipe
 */
`timescale 1ns/10ps
`default_nettype none

module divsqrt_top #(
  parameter int unsigned               NumPipeRegs = 0,
  parameter divsqrt_pkg::pipe_config_e PipeConfig  = divsqrt_pkg::AFTER
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  divsqrt_pkg::in_req_t  in_req_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output divsqrt_pkg::out_rsp_t out_rsp_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  // Distributed placement puts the odd register after the unit
  localparam int unsigned NUM_INP_REGS =
    (PipeConfig == divsqrt_pkg::BEFORE)      ? NumPipeRegs :
    (PipeConfig == divsqrt_pkg::DISTRIBUTED) ? (NumPipeRegs / 2) : 0;
  localparam int unsigned NUM_OUT_REGS =
    (PipeConfig == divsqrt_pkg::AFTER)       ? NumPipeRegs :
    (PipeConfig == divsqrt_pkg::DISTRIBUTED) ? ((NumPipeRegs + 1) / 2) : 0;

  divsqrt_pkg::in_req_t              req;
  divsqrt_pkg::out_rsp_t             rsp;
  logic                              req_valid, req_ready;
  logic                              rsp_valid, rsp_ready;
  logic                              start, unit_busy, unit_done;
  logic [divsqrt_pkg::MAX_WIDTH-1:0] unit_result;
  divsqrt_pkg::status_t              unit_status;
  logic                              inp_busy, ctrl_busy, out_busy;

  divsqrt_pipe #(
    .NumRegs   (NUM_INP_REGS),
    .payload_t (divsqrt_pkg::in_req_t)
  ) u_inp_pipe (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (in_valid_i), .ready_o (in_ready_o), .data_i (in_req_i),
    .valid_o (req_valid),  .ready_i (req_ready),  .data_o (req),
    .busy_o  (inp_busy)
  );

  divsqrt_ctrl u_ctrl (
    .clk_i, .rst_n_i, .flush_i,
    .req_i (req), .req_valid_i (req_valid), .req_ready_o (req_ready),
    .start_o (start), .unit_busy_i (unit_busy), .unit_done_i (unit_done),
    .unit_result_i (unit_result), .unit_status_i (unit_status),
    .rsp_o (rsp), .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready),
    .busy_o (ctrl_busy)
  );

  // Operands go straight from the input pipe, qualified by start
  divsqrt_iter_unit u_unit (
    .clk_i, .rst_n_i, .flush_i,
    .start_i (start), .op_i (req.op), .fmt_i (req.fmt),
    .opa_i (req.opa), .opb_i (req.opb),
    .busy_o (unit_busy), .done_o (unit_done),
    .result_o (unit_result), .status_o (unit_status)
  );

  divsqrt_pipe #(
    .NumRegs   (NUM_OUT_REGS),
    .payload_t (divsqrt_pkg::out_rsp_t)
  ) u_out_pipe (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (rsp_valid),   .ready_o (rsp_ready),   .data_i (rsp),
    .valid_o (out_valid_o), .ready_i (out_ready_i), .data_o (out_rsp_o),
    .busy_o  (out_busy)
  );

  assign busy_o = inp_busy | ctrl_busy | out_busy;  // Work anywhere in flight

endmodule

`default_nettype wire

// File: dv/divsqrt_assertions.sv
/*
 * Handshake and reset assertions for the divide / square-root top level
 * Bound into divsqrt_top
 */
`timescale 1ns/10ps
`default_nettype none

module divsqrt_assertions (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  flush_i,
  input divsqrt_pkg::in_req_t  in_req_i,
  input logic                  in_valid_i,
  input logic                  in_ready_o,
  input divsqrt_pkg::out_rsp_t out_rsp_o,
  input logic                  out_valid_o,
  input logic                  out_ready_i,
  input logic                  busy_o
);

  int unsigned fail_count = 0;  // Read back by the testbench

  // ------------------------------------------------------------------
  // Valid/ready rules
  // ------------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_req_i))
  else begin
    fail_count++;
    $error("input request dropped or changed before it was accepted");
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(out_rsp_o))
  else begin
    fail_count++;
    $error("output response dropped or changed before it was taken");
  end

  // Flush empties everything within one cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_o && !busy_o)
  else begin
    fail_count++;
    $error("work still visible one cycle after flush");
  end

  // Idle outputs while reset is held
  assert property (@(posedge clk_i) !rst_n_i |-> in_ready_o && !out_valid_o && !busy_o)
  else begin
    fail_count++;
    $error("outputs not idle during reset");
  end

endmodule

`default_nettype wire

// File: dv/tb_divsqrt_checks.svh
/*
 * Compare tasks for the divide / square-root testbench
 * One task per kind of DUT result, typed to the DUT's own payloads
 */
`ifndef TB_DIVSQRT_CHECKS_SVH
`define TB_DIVSQRT_CHECKS_SVH

  task automatic check_result(input string name,
                              input logic [divsqrt_pkg::MAX_WIDTH-1:0] exp, act);
    if (act !== exp) begin
      $display("mismatch %s result expected 0x%08h actual 0x%08h", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_status(input string name, input divsqrt_pkg::status_t exp, act);
    if (act !== exp) begin
      $display("mismatch %s status expected dz=%0b nx=%0b actual dz=%0b nx=%0b",
               name, exp.dz, exp.nx, act.dz, act.nx);
      mismatch_count++;
    end
  endtask

  // Tag and mask must come back with their own result
  task automatic check_sideband(input string name, input divsqrt_pkg::sideband_t exp, act);
    if (act !== exp) begin
      $display("mismatch %s sideband expected tag=%0d mask=%0b actual tag=%0d mask=%0b",
               name, exp.tag, exp.mask, act.tag, act.mask);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, act);
    if (act !== exp) begin
      $display("mismatch %s expected %0b actual %0b", name, exp, act);
      mismatch_count++;
    end
  endtask

`endif

// File: dv/tb_divsqrt.sv
/*
 * Testbench for the divide / square-root unit
 * Table driven requests, in-order scoreboard under random back-pressure,
 * flush with work in flight and a watchdog
 */
`timescale 1ns/10ps
`default_nettype none

module tb_divsqrt;

  localparam int unsigned SEED          = 4701;
  localparam int unsigned FLUSH_ITEMS   = 3;   // Dropped by the flush
  localparam int unsigned RERUN_ITEMS   = 6;   // Run again after the flush
  localparam int unsigned QUIET_CYCLES  = 50;  // Window watched for stray responses
  localparam int unsigned CYCLES_PER_OP = 80;
  localparam int          READY_LOW     = 0;
  localparam int          READY_RANDOM  = 1;

  logic                  clk_i, rst_n_i, flush_i;
  divsqrt_pkg::in_req_t  in_req_i;
  logic                  in_valid_i, in_ready_o;
  divsqrt_pkg::out_rsp_t out_rsp_o;
  logic                  out_valid_o, out_ready_i, busy_o;

  int          ready_mode;
  logic        table_ready = 1'b0;
  int unsigned mismatch_count = 0;
  int unsigned other_count = 0;
  int unsigned sent_count = 0;   // Responses expected
  int unsigned resp_count = 0;   // Responses seen

  // Stimulus table, one entry per index
  string                 case_name[$];
  divsqrt_pkg::in_req_t  case_req[$];
  divsqrt_pkg::out_rsp_t case_exp[$];

  // Scoreboard, in issue order
  divsqrt_pkg::out_rsp_t exp_q[$];
  string                 exp_name[$];

  `include "tb_divsqrt_checks.svh"

  divsqrt_top #(
    .NumPipeRegs (2),
    .PipeConfig  (divsqrt_pkg::DISTRIBUTED)
  ) DUT (
    .clk_i, .rst_n_i, .flush_i,
    .in_req_i, .in_valid_i, .in_ready_o,
    .out_rsp_o, .out_valid_o, .out_ready_i,
    .busy_o
  );

  bind divsqrt_top divsqrt_assertions u_sva (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
    .in_req_i (in_req_i), .in_valid_i (in_valid_i), .in_ready_o (in_ready_o),
    .out_rsp_o (out_rsp_o), .out_valid_o (out_valid_o), .out_ready_i (out_ready_i),
    .busy_o (busy_o)
  );

  // ------------------------------------------------------------------
  // Reference model and table
  // ------------------------------------------------------------------
  function automatic divsqrt_pkg::out_rsp_t expected_rsp(divsqrt_pkg::in_req_t req);
    divsqrt_pkg::out_rsp_t rsp;
    int unsigned           w;
    int                    bit_i;
    logic [63:0]           mask, a, b, root, cand;
    w = (req.fmt == divsqrt_pkg::W8) ? 8 : (req.fmt == divsqrt_pkg::W16) ? 16 : 32;
    mask = (64'd1 << w) - 64'd1;
    a = {32'd0, req.opa} & mask;     // Narrow formats read the low bits
    b = {32'd0, req.opb} & mask;
    rsp.sb = req.sb;
    rsp.status = '0;
    if (req.op == divsqrt_pkg::DIV) begin
      if (b == 64'd0) begin
        rsp.result = '1;
        rsp.status.dz = 1'b1;
      end else begin
        rsp.result = 32'((a / b) | ~mask);  // Ones above the format
        rsp.status.nx = ((a % b) != 64'd0);
      end
    end else begin
      // Floor root, built one bit at a time from the top
      root = 64'd0;
      for (bit_i = 15; bit_i >= 0; bit_i--) begin
        cand = root | (64'd1 << bit_i);
        if (cand * cand <= a) root = cand;
      end
      rsp.result = 32'(root | ~mask);
      rsp.status.nx = ((root * root) != a);
    end
    return rsp;
  endfunction

  task automatic add_case(input string name, input logic [1:0] op,
                          input divsqrt_pkg::fp_format_e fmt,
                          input logic [31:0] opa, opb);
    divsqrt_pkg::in_req_t req;
    int                   idx;
    idx = case_name.size();
    req.opa = opa;
    req.opb = opb;
    req.op = divsqrt_pkg::operation_e'(op);  // Codes 2 and 3 kept raw
    req.fmt = fmt;
    req.sb.tag = 8'(idx);
    req.sb.mask = ((idx % 3) == 0);
    case_name.push_back(name);
    case_req.push_back(req);
    case_exp.push_back(expected_rsp(req));
  endtask

  task automatic build_table();
    add_case("div8_rem",        divsqrt_pkg::DIV,  divsqrt_pkg::W8,  32'd200,       32'd7);
    add_case("div8_exact",      divsqrt_pkg::DIV,  divsqrt_pkg::W8,  32'd144,       32'd12);
    add_case("div8_high_bits",  divsqrt_pkg::DIV,  divsqrt_pkg::W8,  32'hABCD_1264, 32'hFFFF_FF05);
    add_case("div16_rem",       divsqrt_pkg::DIV,  divsqrt_pkg::W16, 32'd50000,     32'd123);
    add_case("div16_exact",     divsqrt_pkg::DIV,  divsqrt_pkg::W16, 32'd65535,     32'd255);
    add_case("div32_exact",     divsqrt_pkg::DIV,  divsqrt_pkg::W32, 32'hFFFF_FFFF, 32'd3);
    add_case("div32_big_div",   divsqrt_pkg::DIV,  divsqrt_pkg::W32, 32'h8000_0001, 32'h8000_0000);
    add_case("div32_tiny_quo",  divsqrt_pkg::DIV,  divsqrt_pkg::W32, 32'd1,         32'hFFFF_FFFF);
    add_case("div8_by_zero",    divsqrt_pkg::DIV,  divsqrt_pkg::W8,  32'd17,        32'd0);
    add_case("div8_masked_zero", divsqrt_pkg::DIV, divsqrt_pkg::W8,  32'd17,        32'h0000_0300);
    add_case("div32_zero_zero", divsqrt_pkg::DIV,  divsqrt_pkg::W32, 32'd0,         32'd0);
    add_case("sqrt8_exact",     divsqrt_pkg::SQRT, divsqrt_pkg::W8,  32'd225,       32'd0);
    add_case("sqrt8_rem",       divsqrt_pkg::SQRT, divsqrt_pkg::W8,  32'd255,       32'd9);
    add_case("sqrt16_rem",      divsqrt_pkg::SQRT, divsqrt_pkg::W16, 32'd50000,     32'd0);
    add_case("sqrt16_zero",     divsqrt_pkg::SQRT, divsqrt_pkg::W16, 32'd0,         32'd0);
    add_case("sqrt32_max",      divsqrt_pkg::SQRT, divsqrt_pkg::W32, 32'hFFFF_FFFF, 32'd0);
    add_case("sqrt32_exact",    divsqrt_pkg::SQRT, divsqrt_pkg::W32, 32'hFFFE_0001, 32'd1);
    add_case("sqrt8_high_bits", divsqrt_pkg::SQRT, divsqrt_pkg::W8,  32'h1234_5651, 32'd0);
    add_case("op2_as_sqrt",     2'd2,              divsqrt_pkg::W16, 32'd1000,      32'd0);
    add_case("op3_as_sqrt",     2'd3,              divsqrt_pkg::W32, 32'd123456789, 32'd5);
  endtask

  // ------------------------------------------------------------------
  // Drive helpers
  // ------------------------------------------------------------------
  task automatic drive_slot();
    @(posedge clk_i);
    #1;                                 // Inputs change just after the edge
  endtask

  // Holds the request until the handshake edge
  task automatic send_case(input int idx, input bit expect_rsp);
    in_req_i = case_req[idx];
    in_valid_i = 1'b1;
    if (expect_rsp) begin
      exp_q.push_back(case_exp[idx]);
      exp_name.push_back(case_name[idx]);
      sent_count++;
    end
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    drive_slot();                       // Accepted on this edge
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  initial begin : clock
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;          // 8 ns period
  end

  // Output back-pressure, the only user of random numbers
  initial begin : backpressure
    void'($urandom(SEED));
    out_ready_i = 1'b0;
    forever begin
      drive_slot();
      if (ready_mode == READY_LOW) out_ready_i = 1'b0;
      else                         out_ready_i = (($urandom % 4) != 0);
    end
  end

  // Transfers are decided at the negedge, nothing changes before the next edge
  initial begin : monitor
    divsqrt_pkg::out_rsp_t exp;
    string                 name;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && out_valid_o && out_ready_i) begin
        resp_count++;
        if (exp_q.size() == 0) begin
          $display("Unexpected response with tag %0d while no request was pending",
                   out_rsp_o.sb.tag);
          other_count++;
        end else begin
          exp = exp_q.pop_front();
          name = exp_name.pop_front();
          check_result(name, exp.result, out_rsp_o.result);
          check_status(name, exp.status, out_rsp_o.status);
          check_sideband(name, exp.sb, out_rsp_o.sb);
        end
      end
    end
  end

  initial begin : watchdog
    int unsigned limit;
    wait (table_ready);
    limit = (case_name.size() + FLUSH_ITEMS + RERUN_ITEMS) * CYCLES_PER_OP
            + QUIET_CYCLES + 50;
    repeat (limit) @(posedge clk_i);
    $display("Timeout after %0d cycles with %0d responses still pending", limit, exp_q.size());
    $display("Test failed");
    $finish;
  end

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin : main
    int          i;
    int unsigned sva_fails;
    rst_n_i = 1'b0;
    flush_i = 1'b0;
    in_valid_i = 1'b0;
    in_req_i = '0;
    ready_mode = READY_RANDOM;
    build_table();
    table_ready = 1'b1;

    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("reset_in_ready", 1'b1, in_ready_o);
    check_flag("reset_out_valid", 1'b0, out_valid_o);
    check_flag("reset_busy", 1'b0, busy_o);

    // Whole table under random back-pressure
    drive_slot();
    for (i = 0; i < case_name.size(); i++) send_case(i, 1'b1);
    wait_drained();

    // Stall the output, fill the unit and both pipes, then flush
    ready_mode = READY_LOW;
    drive_slot();
    for (i = 0; i < FLUSH_ITEMS; i++) send_case(i, 1'b0);
    @(negedge clk_i);
    while (!out_valid_o) @(negedge clk_i);
    drive_slot();
    flush_i = 1'b1;
    drive_slot();
    flush_i = 1'b0;
    @(negedge clk_i);
    check_flag("flush_busy", 1'b0, busy_o);
    check_flag("flush_out_valid", 1'b0, out_valid_o);
    check_flag("flush_in_ready", 1'b1, in_ready_o);
    ready_mode = READY_RANDOM;
    repeat (QUIET_CYCLES) @(negedge clk_i);  // Monitor flags any stray response

    // Normal work again after the flush
    drive_slot();
    for (i = 0; i < RERUN_ITEMS; i++) send_case(i, 1'b1);
    wait_drained();
    repeat (5) @(negedge clk_i);
    check_flag("idle_at_end", 1'b0, busy_o);
    if (resp_count != sent_count) begin
      $display("mismatch response_count expected %0d actual %0d", sent_count, resp_count);
      mismatch_count++;
    end

    sva_fails = DUT.u_sva.fail_count;
    $display("Summary: %0d responses, %0d mismatches, %0d other errors, %0d assertion failures",
             resp_count, mismatch_count, other_count, sva_fails);
    if ((mismatch_count + other_count + sva_fails) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+dv
common/divsqrt_pkg.sv
divsqrt/divsqrt_pipe.sv
divsqrt/divsqrt_ctrl.sv
divsqrt/divsqrt_iter_unit.sv
verilog/divsqrt_top.sv
dv/divsqrt_assertions.sv
dv/tb_divsqrt.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the divide / square-root testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_divsqrt \
  -f project.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Raised error limit lets assertion failures reach the testbench summary
sim_out=$(./obj_dir/sim_tb +verilator+error+limit+1000 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test passed" <<< "$sim_out"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
